// File: tb.f
+incdir+hw
+incdir+testbench
hw/cpuPkg.sv
hw/alu.sv
hw/dataRam.sv
hw/registerFile.sv
hw/instructionProcessor.sv
hw/processorTop.sv
testbench/tbProcessor.sv

// File: Makefile
# Verilator flow for the processor testbench
# usage: make lint | make sim | make clean, variables may be overridden

VERILATOR ?= verilator
TOP       ?= tbProcessor
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_TEXT ?= === FAIL ===
VFLAGS    ?= --timing --assert

BINARY  := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh testbench/*.sv testbench/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BINARY)
	@./$(BINARY) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/processorModel.svh
/* Reference model of the core for tbProcessor, stepped once per instruction.
   Included inside the testbench module; it mirrors registers, flags, RAM and ip. */
`ifndef PROCESSOR_MODEL_SVH
`define PROCESSOR_MODEL_SVH

logic [15:0]     modelRegs [8];     // r0..r5, sp, ip
logic [15:0]     modelRam [256];
cpuPkg::aluFlags modelFlags;
logic [14:0]     modelOut;          // expected instructionOut

task automatic modelReset();
    for (int i = 0; i < 8; i++) begin
        modelRegs[i] = 16'd0;
    end
    modelFlags = '0;
    modelOut   = `NOP_WORD;
endtask

function automatic logic condPasses(input logic [3:0] cond, input cpuPkg::aluFlags f);
    logic less;
    logic above;
    less  = f.sign ^ f.overflow;    // signed less than
    above = f.carry && !f.zero;
    case (cond)
        `COND_EQ: return f.zero;
        `COND_NE: return !f.zero;
        `COND_GT: return !f.zero && !less;
        `COND_LT: return less;
        `COND_GE: return !less;
        `COND_LE: return f.zero || less;
        `COND_CS: return f.carry;
        `COND_CC: return !f.carry;
        `COND_MI: return f.sign;
        `COND_PL: return !f.sign;
        `COND_AL: return 1'b1;
        `COND_VS: return f.overflow;
        `COND_VC: return !f.overflow;
        `COND_HI: return above;
        `COND_LS: return !above;
        default:  return 1'b0;
    endcase
endfunction

function automatic cpuPkg::aluOut aluModel(input logic [3:0] op, input logic [15:0] a,
                                           input logic [15:0] b, input logic cin);
    cpuPkg::aluOut r;
    logic [31:0]   wide;
    int            total;
    r = '0;
    case (op)
        `ALU_ADD, `ALU_ADDC: begin
            wide             = 32'(a) + 32'(b) + 32'(cin);
            total            = int'($signed(a)) + int'($signed(b)) + int'(cin);
            r.value          = wide[15:0];
            r.flags.carry    = (wide > 32'h0000_ffff);
            r.flags.overflow = (total > 32767) || (total < -32768);
        end
        `ALU_SUB, `ALU_SUBC: begin
            total            = int'($signed(a)) - int'($signed(b)) - int'(cin);
            r.value          = a - b - 16'(cin);
            r.flags.carry    = (32'(a) < 32'(b) + 32'(cin));   // borrow
            r.flags.overflow = (total > 32767) || (total < -32768);
        end
        `ALU_MUL: begin
            wide          = 32'(a) * 32'(b);
            r.value       = wide[15:0];
            r.flags.carry = (wide[31:16] != 16'd0);
        end
        `ALU_AND: r.value = a & b;
        `ALU_OR:  r.value = a | b;
        `ALU_XOR: r.value = a ^ b;
        `ALU_SHL: begin
            r.value       = {a[14:0], 1'b0};
            r.flags.carry = a[15];
        end
        `ALU_SHR: begin
            r.value       = {1'b0, a[15:1]};
            r.flags.carry = a[0];
        end
        default: r.value = a;
    endcase
    r.flags.zero = (r.value == 16'd0);
    r.flags.sign = r.value[15];
    return r;
endfunction

task automatic modelExecute(input logic [15:0] word);
    cpuPkg::instrWord w;
    cpuPkg::aluOut    res;
    logic [15:0]      a;
    logic [15:0]      b;
    logic [15:0]      nextIp;
    logic [15:0]      wdata;
    logic [4:0]       immOp;
    logic [2:0]       dest;
    logic             holds;
    logic             doWrite;
    logic             cin;
    w       = word;
    a       = modelRegs[w.regForm.rd];
    b       = modelRegs[w.regForm.rs];
    immOp   = w.immForm.immOp;
    holds   = condPasses(w.regForm.cond, modelFlags);
    nextIp  = modelRegs[`REG_IP] + 16'd1;
    dest    = w.regForm.rd;
    wdata   = 16'd0;
    doWrite = 1'b0;
    modelOut = `NOP_WORD;
    if (w.regForm.coproc) begin
        modelOut = word[14:0];
    end else if (w.regForm.isAlu) begin
        cin = modelFlags.carry
              && (w.regForm.opcode == `ALU_ADDC || w.regForm.opcode == `ALU_SUBC);
        res = aluModel(w.regForm.opcode, a, b, cin);
        if (holds) begin
            doWrite    = 1'b1;
            wdata      = res.value;
            modelFlags = res.flags;
        end
    end else if (immOp >= `IMM_MOVH && immOp < `IMM_END) begin
        doWrite = 1'b1;     // immediates ignore the condition
        if (immOp >= `IMM_MOVF) begin
            dest  = 3'(immOp - `IMM_MOVF);
            wdata = {12'd0, modelFlags};
        end else if (immOp >= `IMM_MOVL) begin
            dest  = 3'(immOp - `IMM_MOVL);
            wdata = {modelRegs[dest][15:8], w.immForm.imm};
        end else begin
            dest  = 3'(immOp - `IMM_MOVH);
            wdata = {w.immForm.imm, modelRegs[dest][7:0]};
        end
    end else if (holds) begin
        case (w.regForm.opcode)
            `OP_LOAD: begin
                doWrite = 1'b1;
                wdata   = modelRam[b[7:0]];
            end
            `OP_STORE: modelRam[b[7:0]] = a;
            `OP_MOVE: begin
                doWrite = 1'b1;
                wdata   = b;
            end
            `OP_JUMP: nextIp = a;
            default: ;
        endcase
    end
    if (doWrite) begin
        modelRegs[dest] = wdata;
    end
    if (!(doWrite && dest == `REG_IP)) begin
        modelRegs[`REG_IP] = nextIp;
    end
endtask

`endif

// File: testbench/tbProcessor.sv
/* Testbench of processorTop. It fills the data RAM through host writes, then runs
   a random program and compares ip, instructionOut and peek against the model. */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module tbProcessor;

    localparam int RAM_WORDS    = 256;
    localparam int RANDOM_STEPS = 1000;
    localparam int STORE_SLOT   = 255;  // holds store r1, [r0]
    localparam int INSTR_COUNT  = RAM_WORDS + RANDOM_STEPS;
    localparam int HOST_CYCLES  = 3 * RAM_WORDS + 8 + 3 * RANDOM_STEPS;
    localparam int WATCHDOG_NS  = (2 * INSTR_COUNT + HOST_CYCLES + 10) * 20 + 2000;

    logic        clock;
    logic        rstN;
    logic [15:0] romData;
    logic [7:0]  regChoose;
    logic [15:0] regData;
    logic [2:0]  peekSel;
    logic [15:0] romAddress;
    logic [14:0] instructionOut;
    logic [15:0] peekData;

    logic [15:0] romImage [256];
    int          checks;
    int          errors;

    `include "processorModel.svh"

    processorTop u_dut (
        .clock          (clock),
        .rstN           (rstN),
        .romData        (romData),
        .regChoose      (regChoose),
        .regData        (regData),
        .peekSel        (peekSel),
        .romAddress     (romAddress),
        .instructionOut (instructionOut),
        .peekData       (peekData)
    );

    always #10 clock = ~clock;

    // program memory read on the falling edge
    initial begin
        romData = 16'd0;
        forever begin
            @(negedge clock);
            romData = romImage[romAddress[7:0]];
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic checkValue(input string what, input logic [15:0] got,
                              input logic [15:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // mostly ALU words with AL on about half the conditional ones
    function automatic logic [15:0] randomWord();
        logic [3:0] cond;
        cond = ($urandom % 2 == 0) ? `COND_AL : 4'($urandom % 16);
        case ($urandom % 16)
            8:  return {2'b00, `OP_LOAD, cond, 3'($urandom % 8), 3'($urandom % 8)};
            9:  return {2'b00, `OP_STORE, cond, 3'($urandom % 8), 3'($urandom % 8)};
            10: return {2'b00, `OP_MOVE, cond, 3'($urandom % 8), 3'($urandom % 8)};
            11: return {2'b00, `OP_JUMP, cond, 3'($urandom % 8), 3'($urandom % 8)};
            12: return {2'b00, `IMM_MOVH + 5'($urandom % 6), 8'($urandom), 1'($urandom)};
            13: return {2'b00, `IMM_MOVL + 5'($urandom % 6), 8'($urandom), 1'($urandom)};
            14: return {2'b00, `IMM_MOVF + 5'($urandom % 6), 8'($urandom), 1'($urandom)};
            15: return {1'b1, 15'($urandom)};     // coprocessor word
            default: return {2'b01, 4'($urandom % 16), cond, 3'($urandom % 8),
                             3'($urandom % 8)};
        endcase
    endfunction

    // one stall cycle from falling edge to falling edge
    task automatic hostWrite(input logic [7:0] mask, input logic [15:0] data);
        regChoose = mask;
        regData   = data;
        @(posedge clock);
        @(negedge clock);
        regChoose = 8'd0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) begin
                modelRegs[i] = data;
            end
        end
    endtask

    // one instruction, sometimes with a host write between decode and execute
    task automatic runInstruction(input logic allowStall);
        logic [15:0] word;
        logic [15:0] prevIp;
        logic [14:0] prevOut;
        logic [7:0]  stallMask;
        word      = romImage[modelRegs[`REG_IP][7:0]];
        prevIp    = modelRegs[`REG_IP];
        prevOut   = modelOut;
        peekSel   = 3'($urandom % 8);
        stallMask = 8'd0;
        // a dropped store has already written the RAM
        if (allowStall && $urandom % 8 == 0 && word[15:10] != {2'b00, `OP_STORE}) begin
            stallMask = 8'd1 << ($urandom % 8);
        end
        @(posedge clock);   // decode
        @(negedge clock);
        checkValue("romAddress in decode", romAddress, prevIp);
        checkValue("instructionOut in decode", {1'b0, instructionOut}, {1'b0, prevOut});
        if (stallMask != 8'd0) begin
            hostWrite(stallMask, 16'($urandom));    // decoded word is dropped
            word = romImage[modelRegs[`REG_IP][7:0]];
            @(posedge clock);   // decode again
            @(negedge clock);
        end
        @(posedge clock);   // execute
        @(negedge clock);
        modelExecute(word);
        checkValue("romAddress", romAddress, modelRegs[`REG_IP]);
        checkValue("instructionOut", {1'b0, instructionOut}, {1'b0, modelOut});
        checkValue($sformatf("peek r%0d", peekSel), peekData, modelRegs[peekSel]);
    endtask

    initial begin
        clock     = 1'b0;
        rstN      = 1'b0;
        regChoose = 8'd0;
        regData   = 16'd0;
        peekSel   = 3'd0;
        checks    = 0;
        errors    = 0;
        void'($urandom(32'hc42bf5a1));
        for (int i = 0; i < 256; i++) begin
            romImage[i] = randomWord();
        end
        romImage[STORE_SLOT] = {2'b00, `OP_STORE, `COND_AL, 3'd1, 3'd0};
        modelReset();

        @(negedge clock);
        checkValue("romAddress after reset", romAddress, 16'd0);
        checkValue("instructionOut after reset", {1'b0, instructionOut}, {1'b0, `NOP_WORD});
        for (int i = 0; i < 8; i++) begin
            peekSel = 3'(i);
            #1;
            checkValue($sformatf("r%0d after reset", i), peekData, 16'd0);
        end
        repeat (3) @(negedge clock);
        rstN = 1'b1;
        @(posedge clock);   // start-up edge with no decode yet
        @(negedge clock);

        // one store per RAM address
        for (int addr = 0; addr < RAM_WORDS; addr++) begin
            hostWrite(8'h01, 16'(addr));
            hostWrite(8'h02, {8'(addr), ~8'(addr)} ^ 16'h3c5a);
            hostWrite(8'h80, 16'(STORE_SLOT));
            runInstruction(1'b0);
        end

        for (int i = 0; i < 7; i++) begin
            hostWrite(8'b1 << i, 16'($urandom));
        end
        hostWrite(8'h80, 16'd0);
        for (int n = 0; n < RANDOM_STEPS; n++) begin
            if ($urandom % 8 == 0) begin
                hostWrite(8'b1 << ($urandom % 8), 16'($urandom));
            end
            runInstruction(1'b1);
        end

        $display("tbProcessor: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/processorTop.sv
/* Top of the 16-bit core: processor, register file, ALU and data RAM.
   Program memory sits outside and is addressed by ip through romAddress. */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module processorTop (
    input  logic                               clock,
    input  logic                               rstN,
    input  logic [`DATA_WIDTH-1:0]             romData,
    input  logic [(1 << `REG_INDEX_BITS)-1:0]  regChoose,
    input  logic [`DATA_WIDTH-1:0]             regData,
    input  logic [`REG_INDEX_BITS-1:0]         peekSel,
    output logic [`DATA_WIDTH-1:0]             romAddress,
    output logic [`DATA_WIDTH-2:0]             instructionOut,
    output logic [`DATA_WIDTH-1:0]             peekData
);

    logic [`REG_INDEX_BITS-1:0] firstSel;
    logic [`REG_INDEX_BITS-1:0] secondSel;
    logic [`DATA_WIDTH-1:0]     firstData;
    logic [`DATA_WIDTH-1:0]     secondData;
    logic [`DATA_WIDTH-1:0]     aluA;
    logic [`DATA_WIDTH-1:0]     aluB;
    logic [3:0]                 aluSel;
    logic                       carryIn;
    cpuPkg::aluOut              aluResult;
    cpuPkg::memRequest          memReq;
    logic [`DATA_WIDTH-1:0]     ramQ;
    cpuPkg::regWrite            write;
    logic [`DATA_WIDTH-1:0]     ipNext;
    logic                       ipLoad;

    instructionProcessor uProcessor (
        .clock          (clock),
        .rstN           (rstN),
        .romData        (romData),
        .regChoose      (regChoose),
        .firstData      (firstData),
        .secondData     (secondData),
        .ipValue        (romAddress),   // ip drives program memory
        .aluResult      (aluResult),
        .ramQ           (ramQ),
        .firstSel       (firstSel),
        .secondSel      (secondSel),
        .aluA           (aluA),
        .aluB           (aluB),
        .aluSel         (aluSel),
        .carryIn        (carryIn),
        .memReq         (memReq),
        .write          (write),
        .ipNext         (ipNext),
        .ipLoad         (ipLoad),
        .instructionOut (instructionOut)
    );

    registerFile uRegisters (
        .clock      (clock),
        .rstN       (rstN),
        .firstSel   (firstSel),
        .secondSel  (secondSel),
        .peekSel    (peekSel),
        .write      (write),
        .regChoose  (regChoose),
        .regData    (regData),
        .ipNext     (ipNext),
        .ipLoad     (ipLoad),
        .firstData  (firstData),
        .secondData (secondData),
        .peekData   (peekData),
        .ipValue    (romAddress)
    );

    alu uAlu (
        .a       (aluA),
        .b       (aluB),
        .aluSel  (aluSel),
        .carryIn (carryIn),
        .result  (aluResult)
    );

    dataRam uRam (
        .clock   (clock),
        .request (memReq),
        .q       (ramQ)
    );

endmodule

`default_nettype wire

// File: hw/instructionProcessor.sv
/* Decode and sequencing of the core, two cycles per instruction.
   The decode edge registers operands and condition, the execute edge commits. */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module instructionProcessor (
    input  logic                               clock,
    input  logic                               rstN,
    input  logic [`DATA_WIDTH-1:0]             romData,
    input  logic [(1 << `REG_INDEX_BITS)-1:0]  regChoose,
    input  logic [`DATA_WIDTH-1:0]             firstData,
    input  logic [`DATA_WIDTH-1:0]             secondData,
    input  logic [`DATA_WIDTH-1:0]             ipValue,
    input  cpuPkg::aluOut                      aluResult,
    input  logic [`DATA_WIDTH-1:0]             ramQ,
    output logic [`REG_INDEX_BITS-1:0]         firstSel,
    output logic [`REG_INDEX_BITS-1:0]         secondSel,
    output logic [`DATA_WIDTH-1:0]             aluA,
    output logic [`DATA_WIDTH-1:0]             aluB,
    output logic [3:0]                         aluSel,
    output logic                               carryIn,
    output cpuPkg::memRequest                  memReq,
    output cpuPkg::regWrite                    write,
    output logic [`DATA_WIDTH-1:0]             ipNext,
    output logic                               ipLoad,
    output logic [`DATA_WIDTH-2:0]             instructionOut
);

    cpuPkg::instrWord               fetched;
    cpuPkg::instrWord               current;    // word under execute
    cpuPkg::aluFlags                flags;
    logic                           phase;      // 0 decode, 1 execute
    logic                           started;
    logic                           hostStall;
    logic                           condNow;
    logic                           condOk;
    logic                           cinNow;
    logic                           flagUpdate;
    logic                           jumpTaken;
    logic [4:0]                     baseNow;
    logic [4:0]                     baseExec;
    logic [`REG_INDEX_BITS-1:0]     destNow;
    logic [`REG_INDEX_BITS-1:0]     destReg;

    // movh/movl/movf base of an immediate word, 0 for anything else
    function automatic logic [4:0] immBase(input cpuPkg::instrWord w);
        logic [4:0] op;
        op = w.immForm.immOp;
        if (w.immForm.coproc || w.immForm.isAlu || op < `IMM_MOVH || op >= `IMM_END) begin
            return 5'd0;
        end
        if (op >= `IMM_MOVF) begin
            return `IMM_MOVF;
        end
        if (op >= `IMM_MOVL) begin
            return `IMM_MOVL;
        end
        return `IMM_MOVH;
    endfunction

    function automatic logic condHolds(input logic [3:0] cond, input cpuPkg::aluFlags f);
        case (cond)
            `COND_EQ: return f.zero;
            `COND_NE: return !f.zero;
            `COND_GT: return !f.zero && (f.sign == f.overflow);
            `COND_LT: return f.sign != f.overflow;
            `COND_GE: return f.sign == f.overflow;
            `COND_LE: return f.zero || (f.sign != f.overflow);
            `COND_CS: return f.carry;
            `COND_CC: return !f.carry;
            `COND_MI: return f.sign;
            `COND_PL: return !f.sign;
            `COND_AL: return 1'b1;
            `COND_VS: return f.overflow;
            `COND_VC: return !f.overflow;
            `COND_HI: return f.carry && !f.zero;
            `COND_LS: return !f.carry || f.zero;
            default:  return 1'b0;  // NV
        endcase
    endfunction

    assign fetched   = romData;
    assign hostStall = |regChoose;

    always_comb begin
        baseNow = immBase(fetched);
        if (baseNow != 5'd0) begin
            destNow = `REG_INDEX_BITS'(fetched.immForm.immOp - baseNow);
        end else begin
            destNow = fetched.regForm.rd;
        end
        condNow = condHolds(fetched.regForm.cond, flags);
        cinNow  = fetched.regForm.isAlu && (fetched.regForm.opcode == `ALU_ADDC
                  || fetched.regForm.opcode == `ALU_SUBC) && flags.carry;
    end

    assign firstSel  = destNow;
    assign secondSel = fetched.regForm.rs;

    // store lands at the decode edge, a load's read is issued there too
    assign memReq.writeEnable = started && !phase && !hostStall
                             && !fetched.regForm.coproc && !fetched.regForm.isAlu
                             && (fetched.regForm.opcode == `OP_STORE) && condNow;
    assign memReq.address     = secondData[`RAM_ADDR_BITS-1:0];
    assign memReq.data        = firstData;

    always_comb begin
        baseExec     = immBase(current);
        write.enable = 1'b0;
        write.index  = destReg;
        write.data   = aluResult.value;
        flagUpdate   = 1'b0;
        jumpTaken    = 1'b0;
        if (phase && !current.regForm.coproc) begin
            if (current.regForm.isAlu) begin
                write.enable = condOk;
                flagUpdate   = condOk;
            end else if (baseExec == `IMM_MOVH) begin
                write.enable = 1'b1;
                write.data   = {current.immForm.imm, aluA[7:0]};
            end else if (baseExec == `IMM_MOVL) begin
                write.enable = 1'b1;
                write.data   = {aluA[`DATA_WIDTH-1:8], current.immForm.imm};
            end else if (baseExec == `IMM_MOVF) begin
                write.enable = 1'b1;
                write.data   = {{(`DATA_WIDTH-4){1'b0}}, flags};
            end else begin
                case (current.regForm.opcode)
                    `OP_LOAD: begin
                        write.enable = condOk;
                        write.data   = ramQ;
                    end
                    `OP_MOVE: begin
                        write.enable = condOk;
                        write.data   = aluB;
                    end
                    `OP_JUMP: jumpTaken = condOk;
                    default:  jumpTaken = 1'b0;     // store done at decode, rest nop
                endcase
            end
        end
        ipNext = jumpTaken ? aluA : ipValue + `DATA_WIDTH'd1;
    end

    assign ipLoad = phase;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            phase          <= 1'b0;
            started        <= 1'b0;
            flags          <= '0;
            instructionOut <= `NOP_WORD;
        end else if (hostStall) begin
            phase <= 1'b0;  // drop pending work, restart at decode
        end else if (!started) begin
            started <= 1'b1;
        end else if (!phase) begin
            phase <= 1'b1;
        end else begin
            phase          <= 1'b0;
            instructionOut <= current.regForm.coproc ? current[`DATA_WIDTH-2:0] : `NOP_WORD;
            if (flagUpdate) begin
                flags <= aluResult.flags;
            end
        end
    end

    // decode registers, reloaded at every edge while in decode
    always_ff @(posedge clock) begin
        if (!phase) begin
            current <= fetched;
            destReg <= destNow;
            aluA    <= firstData;
            aluB    <= secondData;
            aluSel  <= fetched.regForm.opcode;
            carryIn <= cinNow;
            condOk  <= condNow;
        end
    end

endmodule

`default_nettype wire

// File: hw/registerFile.sv
/* Eight registers r0 to r5, sp and ip, with two operand reads and a peek read.
   Host writes win; otherwise write-back and the ip update are applied. */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module registerFile (
    input  logic                               clock,
    input  logic                               rstN,
    input  logic [`REG_INDEX_BITS-1:0]         firstSel,
    input  logic [`REG_INDEX_BITS-1:0]         secondSel,
    input  logic [`REG_INDEX_BITS-1:0]         peekSel,
    input  cpuPkg::regWrite                    write,
    input  logic [(1 << `REG_INDEX_BITS)-1:0]  regChoose,
    input  logic [`DATA_WIDTH-1:0]             regData,
    input  logic [`DATA_WIDTH-1:0]             ipNext,
    input  logic                               ipLoad,
    output logic [`DATA_WIDTH-1:0]             firstData,
    output logic [`DATA_WIDTH-1:0]             secondData,
    output logic [`DATA_WIDTH-1:0]             peekData,
    output logic [`DATA_WIDTH-1:0]             ipValue
);

    logic [`DATA_WIDTH-1:0] regs [(1 << `REG_INDEX_BITS)];
    logic                   writesIp;

    assign writesIp = write.enable && (write.index == `REG_IP);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < (1 << `REG_INDEX_BITS); i++) begin
                regs[i] <= '0;
            end
        end else if (|regChoose) begin
            // one-hot in use, but every set bit is honoured
            for (int i = 0; i < (1 << `REG_INDEX_BITS); i++) begin
                if (regChoose[i]) begin
                    regs[i] <= regData;
                end
            end
        end else begin
            if (write.enable) begin
                regs[write.index] <= write.data;
            end
            if (ipLoad && !writesIp) begin
                regs[`REG_IP] <= ipNext;    // write to ip replaces increment
            end
        end
    end

    assign firstData  = regs[firstSel];
    assign secondData = regs[secondSel];
    assign peekData   = regs[peekSel];
    assign ipValue    = regs[`REG_IP];

endmodule

`default_nettype wire

// File: hw/dataRam.sv
/* Private data RAM of the core, 256 words.
   Writes on the clock edge and registers the read of the addressed word. */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module dataRam (
    input  logic                   clock,
    input  cpuPkg::memRequest      request,
    output logic [`DATA_WIDTH-1:0] q
);

    logic [`DATA_WIDTH-1:0] mem [(1 << `RAM_ADDR_BITS)];

    always_ff @(posedge clock) begin
        if (request.writeEnable) begin
            mem[request.address] <= request.data;
        end
        q <= mem[request.address];  // old word on a same-edge write
    end

endmodule

`default_nettype wire

// File: hw/alu.sv
/* Combinational ALU of the core.
   Gives the result and the carry, sign, overflow and zero flags for aluSel. */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  logic [3:0]             aluSel,
    input  logic                   carryIn,
    output cpuPkg::aluOut          result
);

    logic [`DATA_WIDTH:0]       wide;       // top bit is carry or borrow
    logic [2*`DATA_WIDTH-1:0]   product;
    logic [`DATA_WIDTH-1:0]     value;
    logic                       carry;
    logic                       overflow;

    assign product = a * b;

    always_comb begin
        wide     = '0;
        value    = a;
        carry    = 1'b0;
        overflow = 1'b0;
        case (aluSel)
            `ALU_ADD, `ALU_ADDC: begin
                wide     = {1'b0, a} + {1'b0, b} + {{`DATA_WIDTH{1'b0}}, carryIn};
                value    = wide[`DATA_WIDTH-1:0];
                carry    = wide[`DATA_WIDTH];
                overflow = (a[`DATA_WIDTH-1] == b[`DATA_WIDTH-1])
                        && (value[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
            end
            `ALU_SUB, `ALU_SUBC: begin
                wide     = {1'b0, a} - {1'b0, b} - {{`DATA_WIDTH{1'b0}}, carryIn};
                value    = wide[`DATA_WIDTH-1:0];
                carry    = wide[`DATA_WIDTH];   // borrow
                overflow = (a[`DATA_WIDTH-1] != b[`DATA_WIDTH-1])
                        && (value[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
            end
            `ALU_MUL: begin
                value = product[`DATA_WIDTH-1:0];
                carry = |product[2*`DATA_WIDTH-1:`DATA_WIDTH];
            end
            `ALU_AND: value = a & b;
            `ALU_OR:  value = a | b;
            `ALU_XOR: value = a ^ b;
            `ALU_SHL: begin
                value = {a[`DATA_WIDTH-2:0], 1'b0};
                carry = a[`DATA_WIDTH-1];
            end
            `ALU_SHR: begin
                value = {1'b0, a[`DATA_WIDTH-1:1]};
                carry = a[0];
            end
            default: value = a;     // pass
        endcase
    end

    assign result.value = value;
    assign result.flags = '{
        zero:     (value == '0),
        overflow: overflow,
        sign:     value[`DATA_WIDTH-1],
        carry:    carry
    };

endmodule

`default_nettype wire

// File: hw/cpuPkg.sv
/* Types shared by the core modules and the reference model.
   Referenced by scoped name, cpuPkg::instrWord and so on. */
`default_nettype none

`include "cpu_defines.svh"

package cpuPkg;

    typedef struct packed {
        logic       coproc;
        logic       isAlu;
        logic [3:0] opcode;
        logic [3:0] cond;
        logic [`REG_INDEX_BITS-1:0] rd;     // destination or first operand
        logic [`REG_INDEX_BITS-1:0] rs;
    } regFormFields;

    typedef struct packed {
        logic       coproc;
        logic       isAlu;
        logic [4:0] immOp;
        logic [7:0] imm;
        logic       spare;
    } immFormFields;

    // one instruction word, two decodings
    typedef union packed {
        regFormFields regForm;
        immFormFields immForm;
    } instrWord;

    // carry sits in bit 0 of the flag word read by movf
    typedef struct packed {
        logic zero;
        logic overflow;
        logic sign;
        logic carry;
    } aluFlags;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] value;
        aluFlags                flags;
    } aluOut;

    typedef struct packed {
        logic                       enable;
        logic [`REG_INDEX_BITS-1:0] index;
        logic [`DATA_WIDTH-1:0]     data;
    } regWrite;

    typedef struct packed {
        logic                      writeEnable;
        logic [`RAM_ADDR_BITS-1:0] address;
        logic [`DATA_WIDTH-1:0]    data;
    } memRequest;

endpackage

`default_nettype wire

// File: hw/cpu_defines.svh
/* Widths and instruction encodings of the core.
   Included by every RTL file that decodes or sizes an instruction field. */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define DATA_WIDTH      16
`define REG_INDEX_BITS  3
`define RAM_ADDR_BITS   8
`define NOP_WORD        15'h42C0    // addnv r0, r0

// ALU opcodes, 10 to 15 pass a
`define ALU_ADD   4'd0
`define ALU_ADDC  4'd1
`define ALU_SUB   4'd2
`define ALU_SUBC  4'd3
`define ALU_MUL   4'd4
`define ALU_AND   4'd5
`define ALU_OR    4'd6
`define ALU_XOR   4'd7
`define ALU_SHL   4'd8
`define ALU_SHR   4'd9

// register form, non-ALU
`define OP_LOAD   4'd0
`define OP_STORE  4'd1
`define OP_MOVE   4'd2
`define OP_JUMP   4'd12

// immediate sub-opcode bases, each followed by r0 to r5
`define IMM_MOVH  5'd6
`define IMM_MOVL  5'd12
`define IMM_MOVF  5'd18
`define IMM_END   5'd24

`define COND_EQ   4'd0
`define COND_NE   4'd1
`define COND_GT   4'd2
`define COND_LT   4'd3
`define COND_GE   4'd4
`define COND_LE   4'd5
`define COND_CS   4'd6
`define COND_CC   4'd7
`define COND_MI   4'd8
`define COND_PL   4'd9
`define COND_AL   4'd10
`define COND_NV   4'd11
`define COND_VS   4'd12
`define COND_VC   4'd13
`define COND_HI   4'd14
`define COND_LS   4'd15

`define REG_SP    3'd6
`define REG_IP    3'd7

`endif
